/* avb_bridge_top.f */
+incdir+.
avb_bridge_pkg.sv
avb_cmd_capture.sv
avb_burst_ctrl.sv
avb_chan_mux.sv
avb_xfer_buf.sv
avb_bridge_top.sv
avb_slave_model.sv
tb_avb_bridge.sv

/* Makefile */
# Verilator flow for the Avalon-MM burst bridge

VERILATOR ?= verilator
TB_TOP    ?= tb_avb_bridge
RTL_TOP   ?= avb_bridge_top
FILELIST  ?= avb_bridge_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= -Wall --timing
PASS_STR  ?= Result: PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# Pass only when the testbench prints the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_avb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "avb_bridge_params.svh"

module tb_avb_bridge;

	import avb_bridge_pkg::*;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_BURSTS   = 21;
	localparam int BURST_BUDGET = 5000; // Cycles allowed per burst
	localparam int MEM_WORDS    = 2 ** (`AVB_ADDR_W - 2);

	logic                             s_avmm_clk;
	logic                             s_avmm_rst_n;
	logic                             avmm_rdnwr;
	logic [1:0]                       avmm_sel;
	logic [`AVB_ADDR_W-1:0]           avmm_offset;
	logic [`AVB_BUF_AW-1:0]           avmm_brstlen;
	logic                             avmm_transvld;
	logic                             host_wr_en;
	logic [`AVB_BUF_AW-1:0]           host_wr_addr;
	logic [`AVB_DATA_W-1:0]           host_wdata;
	logic [`AVB_BUF_AW-1:0]           host_rd_addr;
	logic [`AVB_DATA_W-1:0]           host_rdata;
	logic                             busy;
	logic                             done;
	avmm_req_t                        avmm_req [`AVB_NUM_CH];
	avmm_rsp_t                        avmm_rsp [`AVB_NUM_CH];
	logic [`AVB_NUM_CH-1:0][3:0]      wait_cfg;
	logic [`AVB_NUM_CH-1:0][3:0]      lat_cfg;

	logic [31:0]            lcg_state = 32'd89297;
	int                     exp_ch;          // Channel that may see requests
	int                     done_cnt = 0;
	int                     bursts_run;
	logic [`AVB_DATA_W-1:0] wbuf_ref [`AVB_BUF_DEPTH];
	logic [`AVB_DATA_W-1:0] ref_mem  [`AVB_NUM_CH][MEM_WORDS];

	avb_bridge_top uut (
		.s_avmm_clk    (s_avmm_clk),
		.s_avmm_rst_n  (s_avmm_rst_n),
		.avmm_rdnwr    (avmm_rdnwr),
		.avmm_sel      (avmm_sel),
		.avmm_offset   (avmm_offset),
		.avmm_brstlen  (avmm_brstlen),
		.avmm_transvld (avmm_transvld),
		.host_wr_en    (host_wr_en),
		.host_wr_addr  (host_wr_addr),
		.host_wdata    (host_wdata),
		.host_rd_addr  (host_rd_addr),
		.host_rdata    (host_rdata),
		.busy          (busy),
		.done          (done),
		.avmm_req      (avmm_req),
		.avmm_rsp      (avmm_rsp)
	);

	avb_slave_model #(.FILL_TAG(8'hA0)) u_ch0 (
		.clk(s_avmm_clk), .rst_n(s_avmm_rst_n), .wait_states(wait_cfg[0]),
		.rd_latency(lat_cfg[0]), .req(avmm_req[0]), .rsp(avmm_rsp[0])
	);
	avb_slave_model #(.FILL_TAG(8'hA1)) u_ch1 (
		.clk(s_avmm_clk), .rst_n(s_avmm_rst_n), .wait_states(wait_cfg[1]),
		.rd_latency(lat_cfg[1]), .req(avmm_req[1]), .rsp(avmm_rsp[1])
	);
	avb_slave_model #(.FILL_TAG(8'hA2)) u_ch2 (
		.clk(s_avmm_clk), .rst_n(s_avmm_rst_n), .wait_states(wait_cfg[2]),
		.rd_latency(lat_cfg[2]), .req(avmm_req[2]), .rsp(avmm_rsp[2])
	);

	initial s_avmm_clk = 1'b0;
	always #(CLK_PERIOD / 2) s_avmm_clk = ~s_avmm_clk;

	always @(posedge s_avmm_clk) begin
		if (s_avmm_rst_n && done)
			done_cnt <= done_cnt + 1;
	end

	//////////////////////////////////////////////////
	// Helpers

	task automatic stop_failed();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
		$display("[ERROR] %0t ns %s: got %h, expected %h", $time, sig, got, exp);
		stop_failed();
	endtask

	task automatic report_problem(string what);
		$display("[ERROR] %0t ns %s", $time, what);
		stop_failed();
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Power-up word of each slave model mixes every address bit
	function automatic logic [31:0] fill_word(int ch, int idx);
		return (32'(idx) * 32'h9E37_79B1) ^ {8'(8'hA0 + ch), 24'h0};
	endfunction

	function automatic logic [31:0] slave_word(int ch, int idx);
		case (ch)
			1:       return u_ch1.mem[idx];
			2:       return u_ch2.mem[idx];
			default: return u_ch0.mem[idx];
		endcase
	endfunction

	function automatic int slave_hits(int ch, int idx);
		case (ch)
			1:       return int'(u_ch1.wr_hits[idx]);
			2:       return int'(u_ch2.wr_hits[idx]);
			default: return int'(u_ch0.wr_hits[idx]);
		endcase
	endfunction

	task automatic load_wbuf(int n);
		for (int i = 0; i < n; i++) begin
			wbuf_ref[i] = lcg_next();
			@(posedge s_avmm_clk);
			host_wr_en   <= 1'b1;
			host_wr_addr <= 8'(i);
			host_wdata   <= wbuf_ref[i];
		end
		@(posedge s_avmm_clk);
		host_wr_en <= 1'b0;
	endtask

	task automatic run_burst(logic rd, logic [1:0] sel, logic [`AVB_ADDR_W-1:0] off,
		logic [`AVB_BUF_AW-1:0] len, logic poke);
		logic [`AVB_NUM_CH-1:0][3:0] ws;
		logic [`AVB_NUM_CH-1:0][3:0] lat;

		for (int c = 0; c < `AVB_NUM_CH; c++) begin
			ws[c]  = 4'(lcg_next() >> 30);       // 0 to 3 wait states
			lat[c] = 4'(1 + (lcg_next() >> 30)); // 1 to 4 cycles
		end
		@(posedge s_avmm_clk);
		wait_cfg      <= ws;
		lat_cfg       <= lat;
		exp_ch        <= (sel == 2'd3) ? 0 : int'(sel);
		avmm_rdnwr    <= rd;
		avmm_sel      <= sel;
		avmm_offset   <= off;
		avmm_brstlen  <= len;
		avmm_transvld <= 1'b1;
		do @(negedge s_avmm_clk); while (!busy);
		@(posedge s_avmm_clk);
		avmm_transvld <= 1'b0;
		if (poke) begin
			@(posedge s_avmm_clk);
			avmm_transvld <= 1'b1; // Second edge in the middle of the burst
			@(negedge s_avmm_clk);
			assert (busy) else report_problem("extra transvld edge fell outside the burst");
		end
		do @(negedge s_avmm_clk); while (!done);
		bursts_run++;
		repeat (8) @(negedge s_avmm_clk);
		assert (done_cnt == bursts_run)
			else report_mismatch("done pulse count", 32'(done_cnt), 32'(bursts_run));
		assert (!busy) else report_mismatch("busy", 32'(busy), 32'd0);
		@(posedge s_avmm_clk);
		avmm_transvld <= 1'b0;
	endtask

	task automatic check_write(int ch, logic [`AVB_ADDR_W-1:0] off, int n);
		int w;

		for (int i = 0; i < n; i++) begin
			w = int'(off >> 2) + i;
			assert (slave_word(ch, w) == wbuf_ref[i])
				else report_mismatch($sformatf("ch%0d mem[%0d]", ch, w),
					slave_word(ch, w), wbuf_ref[i]);
			assert (slave_hits(ch, w) == 1)
				else report_mismatch($sformatf("ch%0d write count at word %0d", ch, w),
					32'(slave_hits(ch, w)), 32'd1);
			ref_mem[ch][w] = wbuf_ref[i];
		end
	endtask

	// Host side read port has one cycle of latency
	task automatic check_read(int ch, logic [`AVB_ADDR_W-1:0] off, int n);
		int w;

		for (int i = 0; i < n; i++) begin
			w = int'(off >> 2) + i;
			@(posedge s_avmm_clk);
			host_rd_addr <= 8'(i);
			@(posedge s_avmm_clk);
			@(negedge s_avmm_clk);
			assert (host_rdata == ref_mem[ch][w])
				else report_mismatch($sformatf("host_rdata[%0d]", i),
					host_rdata, ref_mem[ch][w]);
		end
	endtask

	//////////////////////////////////////////////////
	// Protocol checks

	a_done_pulse: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		done |=> !done) else report_problem("done stayed high for more than one cycle");

	a_done_ends_busy: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		done |=> !busy) else report_problem("busy stayed high after done");

	a_busy_holds: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		(busy && !done) |=> busy) else report_problem("busy dropped before done");

	a_start_busy: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		uut.start |=> busy) else report_problem("busy did not follow start");

	for (genvar c = 0; c < `AVB_NUM_CH; c++) begin : g_route
		a_route: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
			(exp_ch != c) |-> (avmm_req[c] == '0))
			else report_problem($sformatf("channel %0d driven while %0d selected", c, exp_ch));

		a_full_word: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
			(avmm_req[c].write || avmm_req[c].read) |-> (avmm_req[c].byte_en == '1))
			else report_mismatch($sformatf("avmm_req[%0d].byte_en", c),
				32'(avmm_req[c].byte_en), 32'hF);

		a_word_addr: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
			(avmm_req[c].write || avmm_req[c].read) |-> (avmm_req[c].addr[1:0] == 2'b00))
			else report_mismatch($sformatf("avmm_req[%0d].addr[1:0]", c),
				32'(avmm_req[c].addr[1:0]), 32'd0);
	end

	initial begin
		repeat (RESET_CYCLES + NUM_BURSTS * BURST_BUDGET) @(posedge s_avmm_clk);
		report_problem("watchdog expired before all bursts finished");
	end

	//////////////////////////////////////////////////
	// Stimulus

	initial begin
		logic [`AVB_ADDR_W-1:0] offs [`AVB_NUM_CH][3];
		logic [`AVB_BUF_AW-1:0] lens [3];
		logic [`AVB_ADDR_W-1:0] off;
		int                     n;

		lens          = '{8'd1, 8'd4, 8'd0}; // 0 is a 256 word burst
		s_avmm_rst_n  = 1'b0;
		avmm_rdnwr    = 1'b0;
		avmm_sel      = 2'd0;
		avmm_offset   = '0;
		avmm_brstlen  = '0;
		avmm_transvld = 1'b0;
		host_wr_en    = 1'b0;
		host_wr_addr  = '0;
		host_wdata    = '0;
		host_rd_addr  = '0;
		wait_cfg      = '0;
		lat_cfg       = {`AVB_NUM_CH{4'd1}};
		exp_ch        = 0;
		bursts_run    = 0;
		for (int c = 0; c < `AVB_NUM_CH; c++)
			for (int w = 0; w < MEM_WORDS; w++)
				ref_mem[c][w] = fill_word(c, w);

		repeat (RESET_CYCLES) @(posedge s_avmm_clk);
		s_avmm_rst_n <= 1'b1;
		@(negedge s_avmm_clk);
		assert (!busy) else report_mismatch("busy", 32'(busy), 32'd0);
		assert (!done) else report_mismatch("done", 32'(done), 32'd0);
		for (int c = 0; c < `AVB_NUM_CH; c++)
			assert (!avmm_req[c].write && !avmm_req[c].read)
				else report_problem($sformatf("channel %0d request active after reset", c));

		// Write bursts into separate regions
		for (int ch = 0; ch < `AVB_NUM_CH; ch++) begin
			for (int k = 0; k < 3; k++) begin
				off = 17'h0400 + 17'(k) * 17'h0800 + 17'(4 * (lcg_next() >> 28));
				n   = (lens[k] == '0) ? `AVB_BUF_DEPTH : int'(lens[k]);
				offs[ch][k] = off;
				load_wbuf(n);
				run_burst(1'b0, 2'(ch), off, lens[k], 1'b0);
				check_write(ch, off, n);
			end
		end

		// Read the same regions back
		for (int ch = 0; ch < `AVB_NUM_CH; ch++) begin
			for (int k = 0; k < 3; k++) begin
				n = (lens[k] == '0) ? `AVB_BUF_DEPTH : int'(lens[k]);
				run_burst(1'b1, 2'(ch), offs[ch][k], lens[k], 1'b0);
				check_read(ch, offs[ch][k], n);
			end
		end

		// Alias select with a stray transvld edge during the write
		load_wbuf(16);
		run_burst(1'b0, 2'd3, 17'h0_8000, 8'd16, 1'b1);
		check_write(0, 17'h0_8000, 16);
		run_burst(1'b1, 2'd3, 17'h0_8000, 8'd16, 1'b0);
		check_read(0, 17'h0_8000, 16);
		run_burst(1'b1, 2'd3, 17'h1_0000, 8'd8, 1'b0); // Untouched power-up words
		check_read(0, 17'h1_0000, 8);

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* avb_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "avb_bridge_params.svh"

module avb_slave_model #(
	parameter logic [7:0] FILL_TAG = 8'hA0 // Top byte of the power-up pattern
) (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire [3:0]                      wait_states, // waitreq cycles before each accept
	input  wire [3:0]                      rd_latency,  // Accept to rdatavld, 1 or more
	input  wire avb_bridge_pkg::avmm_req_t req,
	output avb_bridge_pkg::avmm_rsp_t      rsp
);

	import avb_bridge_pkg::*;

	localparam int WORDS = 2 ** (`AVB_ADDR_W - 2);

	logic [`AVB_DATA_W-1:0] mem     [WORDS];
	int unsigned            wr_hits [WORDS]; // Writes seen per word address
	logic [3:0]             wait_cnt;
	logic [3:0]             lat_cnt;
	logic                   rd_pend;
	logic [`AVB_DATA_W-1:0] rd_word;
	logic [`AVB_DATA_W-1:0] rdata_q;
	logic                   rdatavld_q;
	logic                   active;
	logic                   take;
	logic [`AVB_ADDR_W-3:0] word_idx;

	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i]     = (32'(i) * 32'h9E37_79B1) ^ {FILL_TAG, 24'h0};
			wr_hits[i] = 0;
		end
	end

	assign active   = req.write | req.read;
	assign take     = active & (wait_cnt >= wait_states);
	assign word_idx = req.addr[`AVB_ADDR_W-1:2];  // Word aligned accesses only
	assign rsp      = {rdata_q, rdatavld_q, active & ~take};

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt   <= '0;
			lat_cnt    <= '0;
			rd_pend    <= 1'b0;
			rd_word    <= '0;
			rdata_q    <= '0;
			rdatavld_q <= 1'b0;
		end else begin
			rdatavld_q <= 1'b0;
			if (take)
				wait_cnt <= '0;
			else if (active)
				wait_cnt <= wait_cnt + 4'd1;
			if (take && req.write) begin
				mem[word_idx]     <= req.wdata;
				wr_hits[word_idx] <= wr_hits[word_idx] + 1;
			end
			// Read data comes back rd_latency cycles after accept
			if (take && req.read) begin
				rd_word <= mem[word_idx];
				lat_cnt <= rd_latency;
				rd_pend <= 1'b1;
			end else if (rd_pend) begin
				if (lat_cnt <= 4'd1) begin
					rdata_q    <= rd_word;
					rdatavld_q <= 1'b1;
					rd_pend    <= 1'b0;
				end else begin
					lat_cnt <= lat_cnt - 4'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* avb_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "avb_bridge_params.svh"

module avb_bridge_top (
	input  wire                            s_avmm_clk,
	input  wire                            s_avmm_rst_n,
	// Command
	input  wire                            avmm_rdnwr,
	input  wire [1:0]                      avmm_sel,
	input  wire [`AVB_ADDR_W-1:0]          avmm_offset,
	input  wire [`AVB_BUF_AW-1:0]          avmm_brstlen,
	input  wire                            avmm_transvld,
	// Host buffer port
	input  wire                            host_wr_en,
	input  wire [`AVB_BUF_AW-1:0]          host_wr_addr,
	input  wire [`AVB_DATA_W-1:0]          host_wdata,
	input  wire [`AVB_BUF_AW-1:0]          host_rd_addr,
	output logic [`AVB_DATA_W-1:0]         host_rdata,
	// Status
	output logic                           busy,
	output logic                           done,
	// Channels
	output avb_bridge_pkg::avmm_req_t      avmm_req [`AVB_NUM_CH],
	input  wire avb_bridge_pkg::avmm_rsp_t avmm_rsp [`AVB_NUM_CH]
);

	import avb_bridge_pkg::*;

	xfer_cmd_t              cmd;
	logic                   start;
	logic                   issue;
	avmm_req_t              req;
	logic                   acc;
	avmm_rsp_t              rsp;
	logic [`AVB_BUF_AW-1:0] wb_rd_idx;
	logic [`AVB_DATA_W-1:0] wb_rdata;
	logic                   rb_wr_en;
	logic [`AVB_BUF_AW-1:0] rb_wr_idx;
	logic [`AVB_DATA_W-1:0] rb_wdata;

	avb_cmd_capture u_cmd_capture (
		.s_avmm_clk    (s_avmm_clk),
		.s_avmm_rst_n  (s_avmm_rst_n),
		.avmm_transvld (avmm_transvld),
		.avmm_rdnwr    (avmm_rdnwr),
		.avmm_sel      (avmm_sel),
		.avmm_offset   (avmm_offset),
		.avmm_brstlen  (avmm_brstlen),
		.busy          (busy),
		.cmd           (cmd),
		.start         (start)
	);

	avb_burst_ctrl u_burst_ctrl (
		.clk       (s_avmm_clk),
		.rst_n     (s_avmm_rst_n),
		.cmd       (cmd),
		.start     (start),
		.wb_rdata  (wb_rdata),
		.acc       (acc),
		.rsp       (rsp),
		.issue     (issue),
		.req       (req),
		.wb_rd_idx (wb_rd_idx),
		.rb_wr_en  (rb_wr_en),
		.rb_wr_idx (rb_wr_idx),
		.rb_wdata  (rb_wdata),
		.busy      (busy),
		.done      (done)
	);

	avb_chan_mux u_chan_mux (
		.clk      (s_avmm_clk),
		.rst_n    (s_avmm_rst_n),
		.issue    (issue),
		.req      (req),
		.sel      (cmd.sel),
		.avmm_rsp (avmm_rsp),
		.avmm_req (avmm_req),
		.acc      (acc),
		.rsp      (rsp)
	);

	avb_xfer_buf u_xfer_buf (
		.clk          (s_avmm_clk),
		.host_wr_en   (host_wr_en),
		.host_wr_addr (host_wr_addr),
		.host_wdata   (host_wdata),
		.host_rd_addr (host_rd_addr),
		.wb_rd_idx    (wb_rd_idx),
		.rb_wr_en     (rb_wr_en),
		.rb_wr_idx    (rb_wr_idx),
		.rb_wdata     (rb_wdata),
		.wb_rdata     (wb_rdata),
		.host_rdata   (host_rdata)
	);

endmodule

`default_nettype wire

/* avb_xfer_buf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "avb_bridge_params.svh"

module avb_xfer_buf (
	input  wire                    clk,
	// Host side
	input  wire                    host_wr_en,
	input  wire [`AVB_BUF_AW-1:0]  host_wr_addr,
	input  wire [`AVB_DATA_W-1:0]  host_wdata,
	input  wire [`AVB_BUF_AW-1:0]  host_rd_addr,
	// Bridge side
	input  wire [`AVB_BUF_AW-1:0]  wb_rd_idx,
	input  wire                    rb_wr_en,
	input  wire [`AVB_BUF_AW-1:0]  rb_wr_idx,
	input  wire [`AVB_DATA_W-1:0]  rb_wdata,
	output logic [`AVB_DATA_W-1:0] wb_rdata,
	output logic [`AVB_DATA_W-1:0] host_rdata
);

	//////////////////////////////////////////////////
	// Write buffer, host fills, bridge drains

	logic [`AVB_DATA_W-1:0] wr_mem [`AVB_BUF_DEPTH];

	always_ff @(posedge clk) begin
		if (host_wr_en)
			wr_mem[host_wr_addr] <= host_wdata;
	end

	// Registered read toward the controller
	always_ff @(posedge clk) begin
		wb_rdata <= wr_mem[wb_rd_idx];
	end

	//////////////////////////////////////////////////
	// Read buffer, bridge fills, host drains

	logic [`AVB_DATA_W-1:0] rd_mem [`AVB_BUF_DEPTH];

	always_ff @(posedge clk) begin
		if (rb_wr_en)
			rd_mem[rb_wr_idx] <= rb_wdata; // Returned channel word
	end

	always_ff @(posedge clk) begin
		host_rdata <= rd_mem[host_rd_addr];
	end

endmodule

`default_nettype wire

/* avb_chan_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "avb_bridge_params.svh"

module avb_chan_mux (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire                            issue,
	input  wire avb_bridge_pkg::avmm_req_t req,
	input  wire avb_bridge_pkg::chan_sel_e sel,
	input  wire avb_bridge_pkg::avmm_rsp_t avmm_rsp [`AVB_NUM_CH],
	output avb_bridge_pkg::avmm_req_t      avmm_req [`AVB_NUM_CH],
	output logic                           acc,
	output avb_bridge_pkg::avmm_rsp_t      rsp
);

	import avb_bridge_pkg::*;

	localparam int CH_W = $clog2(`AVB_NUM_CH);

	avmm_req_t       req_q;  // The single open request
	logic [CH_W-1:0] ch_dec;
	logic [CH_W-1:0] ch_q;   // Channel the request went to
	logic            req_open;
	logic            chan_wait;

	// Alias select falls through to channel 0
	always_comb begin
		case (sel)
			CH1:     ch_dec = CH_W'(1);
			CH2:     ch_dec = CH_W'(2);
			default: ch_dec = '0;
		endcase
	end

	assign req_open  = req_q.write | req_q.read;
	assign chan_wait = avmm_rsp[ch_q].waitreq;

	//////////////////////////////////////////////////
	// Request hold and retire

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_q <= '0;
			ch_q  <= '0;
			acc   <= 1'b0;
		end else begin
			acc <= req_q.write & ~chan_wait; // Write taken on the last edge
			if (issue) begin
				req_q <= req;
				ch_q  <= ch_dec;
			end else if (req_open && !chan_wait) begin
				req_q <= '0;                 // Slave took it
			end
		end
	end

	// Only the addressed channel sees the request
	always_comb begin
		for (int i = 0; i < `AVB_NUM_CH; i++) begin
			avmm_req[i] = (ch_q == CH_W'(i)) ? req_q : '0;
		end
	end

	//////////////////////////////////////////////////
	// Response path, one register stage

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rsp <= '0;
		else
			rsp <= avmm_rsp[ch_q];
	end

	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(req_open && chan_wait) |=> ($stable(req_q) && $stable(ch_q)));

endmodule

`default_nettype wire

/* avb_burst_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "avb_bridge_params.svh"

module avb_burst_ctrl (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire avb_bridge_pkg::xfer_cmd_t cmd,
	input  wire                       start,
	input  wire [`AVB_DATA_W-1:0]     wb_rdata,
	input  wire                       acc,
	input  wire avb_bridge_pkg::avmm_rsp_t rsp,
	output logic                      issue,
	output avb_bridge_pkg::avmm_req_t req,
	output logic [`AVB_BUF_AW-1:0]    wb_rd_idx,
	output logic                      rb_wr_en,
	output logic [`AVB_BUF_AW-1:0]    rb_wr_idx,
	output logic [`AVB_DATA_W-1:0]    rb_wdata,
	output logic                      busy,
	output logic                      done
);

	import avb_bridge_pkg::*;

	burst_state_e cur_st;
	burst_state_e nxt_st;

	logic [`AVB_BUF_AW:0]   words_left; // One bit wider to hold a full buffer
	logic [`AVB_ADDR_W-1:0] addr_q;
	logic [`AVB_BUF_AW-1:0] buf_idx;    // Burst relative word index
	logic                   last_word;
	logic                   xfer_open;  // Issued and not yet answered

	assign last_word = (words_left == (`AVB_BUF_AW+1)'(1));

	//////////////////////////////////////////////////
	// State register and next state

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cur_st <= B_IDLE;
		else
			cur_st <= nxt_st;
	end

	always_comb begin
		nxt_st = cur_st;
		case (cur_st)
			B_IDLE:     if (start) nxt_st = B_CMD;
			B_CMD:      nxt_st = (cmd.op == XFER_WR) ? B_WR_FETCH : B_RD_ISSUE;
			B_WR_FETCH: nxt_st = B_WR_ISSUE; // Buffer read latency
			B_WR_ISSUE: nxt_st = B_WR_WAIT;
			B_WR_WAIT:  if (acc) nxt_st = B_WR_NEXT;
			B_WR_NEXT:  nxt_st = last_word ? B_END : B_WR_FETCH;
			B_RD_ISSUE: nxt_st = B_RD_WAIT;
			B_RD_WAIT:  if (rsp.rdatavld) nxt_st = B_RD_NEXT;
			B_RD_NEXT:  nxt_st = last_word ? B_END : B_RD_ISSUE;
			B_END:      nxt_st = B_IDLE;
			default:    nxt_st = B_IDLE;
		endcase
	end

	//////////////////////////////////////////////////
	// Word count, address and buffer index

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			words_left <= '0;
			addr_q     <= '0;
			buf_idx    <= '0;
		end else begin
			case (cur_st)
				B_CMD: begin
					if (cmd.brstlen == '0)
						words_left <= (`AVB_BUF_AW+1)'(`AVB_BUF_DEPTH);
					else
						words_left <= {1'b0, cmd.brstlen};
					addr_q  <= cmd.offset;
					buf_idx <= '0;
				end
				B_WR_NEXT, B_RD_NEXT: begin
					words_left <= words_left - 1'b1;
					addr_q     <= addr_q + `AVB_ADDR_W'(4); // Next full word
					buf_idx    <= buf_idx + 1'b1;
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Outputs decoded from state

	assign issue = (cur_st == B_WR_ISSUE) | (cur_st == B_RD_ISSUE);

	always_comb begin
		req         = '0;
		req.addr    = addr_q;
		req.byte_en = '1;                   // Whole words only
		req.write   = (cur_st == B_WR_ISSUE);
		req.read    = (cur_st == B_RD_ISSUE);
		if (cur_st == B_WR_ISSUE)
			req.wdata = wb_rdata;           // Fetched the cycle before
	end

	assign wb_rd_idx = buf_idx;
	assign rb_wr_en  = (cur_st == B_RD_WAIT) & rsp.rdatavld;
	assign rb_wr_idx = buf_idx;
	assign rb_wdata  = rsp.rdata;

	assign busy = (cur_st != B_IDLE);
	assign done = (cur_st == B_END);

	// Set by issue and cleared by the write accept or the read return
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			xfer_open <= 1'b0;
		else if (issue)
			xfer_open <= 1'b1;
		else if (acc || rsp.rdatavld)
			xfer_open <= 1'b0;
	end

	// One access open at a time toward the fabric
	a_single_issue: assert property (@(posedge clk) disable iff (!rst_n)
		issue |-> !xfer_open);

	// Direction on the fabric follows the captured command
	a_req_dir: assert property (@(posedge clk) disable iff (!rst_n)
		issue |-> (req.read == (cmd.op == XFER_RD)) && (req.write == (cmd.op == XFER_WR)));

endmodule

`default_nettype wire

/* avb_cmd_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "avb_bridge_params.svh"

module avb_cmd_capture (
	input  wire                       s_avmm_clk,
	input  wire                       s_avmm_rst_n,
	input  wire                       avmm_transvld, // Only the rising edge of this level counts
	input  wire                       avmm_rdnwr,
	input  wire [1:0]                 avmm_sel,
	input  wire [`AVB_ADDR_W-1:0]     avmm_offset,
	input  wire [`AVB_BUF_AW-1:0]     avmm_brstlen,
	input  wire                       busy,
	output avb_bridge_pkg::xfer_cmd_t cmd,
	output logic                      start
);

	import avb_bridge_pkg::*;

	logic transvld_d1;
	logic transvld_up;
	logic take_cmd;

	assign transvld_up = avmm_transvld & ~transvld_d1;

	// No new command while a burst runs
	assign take_cmd = transvld_up & ~busy;

	always_ff @(posedge s_avmm_clk or negedge s_avmm_rst_n) begin
		if (!s_avmm_rst_n) begin
			transvld_d1 <= 1'b0;
			start       <= 1'b0;
		end else begin
			transvld_d1 <= avmm_transvld;
			start       <= take_cmd; // One cycle pulse
		end
	end

	// Held until the next accepted edge
	always_ff @(posedge s_avmm_clk) begin
		if (take_cmd) begin
			cmd.op      <= avmm_rdnwr ? XFER_RD : XFER_WR;
			cmd.sel     <= chan_sel_e'(avmm_sel);
			cmd.offset  <= avmm_offset;
			cmd.brstlen <= avmm_brstlen;
		end
	end

	// busy comes back from the controller one cycle after start
	a_start_not_busy: assert property (@(posedge s_avmm_clk) disable iff (!s_avmm_rst_n)
		start |-> !busy ##1 busy);

endmodule

`default_nettype wire

/* avb_bridge_pkg.sv */
`default_nettype none

`include "avb_bridge_params.svh"

package avb_bridge_pkg;

	//////////////////////////////////////////////////
	// Encodings

	typedef enum logic {
		XFER_WR = 1'b0,
		XFER_RD = 1'b1
	} xfer_op_e;

	// Select value 3 lands on channel 0
	typedef enum logic [1:0] {
		CH0       = 2'd0,
		CH1       = 2'd1,
		CH2       = 2'd2,
		CH_ALIAS0 = 2'd3
	} chan_sel_e;

	typedef enum logic [3:0] {
		B_IDLE     = 4'h0,
		B_CMD      = 4'h1,
		B_WR_FETCH = 4'h2,
		B_WR_ISSUE = 4'h3,
		B_WR_WAIT  = 4'h4,
		B_WR_NEXT  = 4'h5,
		B_RD_ISSUE = 4'h6,
		B_RD_WAIT  = 4'h7,
		B_RD_NEXT  = 4'h8,
		B_END      = 4'h9
	} burst_state_e;

	//////////////////////////////////////////////////
	// Bundles

	typedef struct packed {
		xfer_op_e               op;
		chan_sel_e              sel;
		logic [`AVB_ADDR_W-1:0] offset;  // Byte offset of first word
		logic [`AVB_BUF_AW-1:0] brstlen; // 0 stands for a full buffer
	} xfer_cmd_t;

	typedef struct packed {
		logic [`AVB_ADDR_W-1:0]   addr;
		logic [`AVB_DATA_W/8-1:0] byte_en;
		logic                     write;
		logic                     read;
		logic [`AVB_DATA_W-1:0]   wdata;
	} avmm_req_t;

	typedef struct packed {
		logic [`AVB_DATA_W-1:0] rdata;
		logic                   rdatavld;
		logic                   waitreq;
	} avmm_rsp_t;

endpackage

`default_nettype wire

/* avb_bridge_params.svh */
`ifndef AVB_BRIDGE_PARAMS_SVH
`define AVB_BRIDGE_PARAMS_SVH

//////////////////////////////////////////////////
// Avalon channel side

`define AVB_ADDR_W 17     // Byte address toward each channel
`define AVB_DATA_W 32     // Full word per access

//////////////////////////////////////////////////
// Register side buffers

`define AVB_BUF_AW 8      // Word index, also the burst length field
`define AVB_BUF_DEPTH 256 // Words per buffer

// Number of slave channels behind the bridge
`define AVB_NUM_CH 3

`endif
